// ==== tb.f ====
+incdir+src
src/cpuInstrPkg.sv
src/cpuAluPkg.sv
src/instrClassifier.sv
src/alu.sv
src/regFile.sv
src/execCore.sv
tb/tbExecCore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tbExecCore -Mdir obj_dir -o simExecCore

./obj_dir/simExecCore | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb/tbExecCore.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module tbExecCore;

    localparam int resetCycles = 4;
    localparam int loadCount = 31;
    localparam int regOpCount = 48;
    localparam int immOpCount = 28;
    localparam int shiftOpCount = 26;
    localparam int leadOpCount = 17;
    localparam int zeroIllegalCount = 37;
    localparam int idleCycles = 2;
    localparam int totalInstr = loadCount + regOpCount + immOpCount + shiftOpCount
                                + leadOpCount + zeroIllegalCount;
    localparam int timeLimitNs = (totalInstr + resetCycles + idleCycles) * 100 * 2;

    // MIPS encodings as the instruction set defines them
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti = 6'h0a;
    localparam logic [5:0] opSltiu = 6'h0b;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opXori = 6'h0e;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLoadWord = 6'h23;
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnSra = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnNor = 6'h27;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;
    localparam logic [5:0] fnClz = 6'h20;
    localparam logic [5:0] fnClo = 6'h21;

    localparam logic [5:0] regFns [8] = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
    localparam logic [5:0] immOps [7] = '{opAndi, opOri, opXori, opSlti, opSltiu, opAddi, opLui};
    localparam logic [5:0] shiftFns [6] = '{fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};

    logic clk;
    logic rst;
    logic instrValid;
    logic [31:0] instr;
    logic [`DATA_WIDTH-1:0] result;
    logic [`REG_ADDR_WIDTH-1:0] resultDest;
    logic resultValid;
    logic illegal;

    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
    int errors;
    int checks;

    execCore u_execCore (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .result      (result),
        .resultDest  (resultDest),
        .resultValid (resultValid),
        .illegal     (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        #(timeLimitNs);
        $display("timeout: the run did not finish within %0d ns", timeLimitNs);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] rWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sa, input logic [5:0] fn);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] randIndex(input int lo, input int hi);
        logic [31:0] r;
        r = $urandom_range(hi, lo);
        return r[4:0];
    endfunction

    function automatic logic [15:0] randImm();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    // logical shift with the vacated high bits then filled with copies of the sign
    function automatic logic [31:0] arithShift(input logic [31:0] value, input logic [4:0] count);
        logic [31:0] res;
        res = value >> count;
        if (value[31])
            res = res | ~(32'hffffffff >> count);
        return res;
    endfunction

    function automatic logic [31:0] leadingCount(input logic [31:0] value, input logic bitVal);
        int n;
        for (n = 0; n < 32; n++)
        begin
            if (value[31 - n] != bitVal)
                break;
        end
        return 32'(n);
    endfunction

    task automatic predict(input logic [31:0] word, output logic legal,
                           output logic [31:0] value, output logic [4:0] dest);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sa;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] zImm;
        op = word[31:26];
        fn = word[5:0];
        sa = word[10:6];
        a = model[word[25:21]];
        b = model[word[20:16]];
        sImm = {{16{word[15]}}, word[15:0]};
        zImm = {16'h0000, word[15:0]};
        legal = 1'b1;
        value = '0;
        dest = word[15:11];
        case (op)
            opSpecial:
            begin
                case (fn)
                    fnAdd, fnAddu: value = a + b;
                    fnSub, fnSubu: value = a - b;
                    fnAnd:         value = a & b;
                    fnOr:          value = a | b;
                    fnXor:         value = a ^ b;
                    fnNor:         value = ~(a | b);
                    fnSlt:         value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSltu:        value = (a < b) ? 32'd1 : 32'd0;
                    fnSll:         value = b << sa;
                    fnSrl:         value = b >> sa;
                    fnSra:         value = arithShift(b, sa);
                    fnSllv:        value = b << a[4:0];
                    fnSrlv:        value = b >> a[4:0];
                    fnSrav:        value = arithShift(b, a[4:0]);
                    default:       legal = 1'b0;
                endcase
            end
            opSpecial2:
            begin
                if (fn == fnClo)
                    value = leadingCount(a, 1'b1);
                else if (fn == fnClz)
                    value = leadingCount(a, 1'b0);
                else
                    legal = 1'b0;
            end
            opAddi, opAddiu: value = a + sImm;
            opSlti:          value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            opSltiu:         value = (a < sImm) ? 32'd1 : 32'd0;
            opAndi:          value = a & zImm;
            opOri:           value = a | zImm;
            opXori:          value = a ^ zImm;
            opLui:           value = {word[15:0], 16'h0000};
            default:         legal = 1'b0;
        endcase
        // immediate forms write rt
        if (op != opSpecial && op != opSpecial2)
            dest = word[20:16];
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // called on a falling edge and returns on the next one with the outputs checked
    task automatic issue(input logic [31:0] word);
        logic expLegal;
        logic [31:0] expValue;
        logic [4:0] expDest;
        predict(word, expLegal, expValue, expDest);
        instr = word;
        instrValid = 1'b1;
        if (expLegal && expDest != 5'd0)
            model[expDest] = expValue;
        @(negedge clk);
        instrValid = 1'b0;
        checkEq("resultValid", {31'b0, resultValid}, {31'b0, expLegal});
        checkEq("illegal", {31'b0, illegal}, {31'b0, !expLegal});
        if (expLegal)
        begin
            checkEq("result", result, expValue);
            checkEq("resultDest", {27'b0, resultDest}, {27'b0, expDest});
        end
    endtask

    task automatic loadRegisters();
        logic [15:0] imm;
        for (int k = 1; k <= loadCount; k++)
        begin
            imm = randImm();
            imm[15] = k[0];
            issue(iWord(opAddiu, 5'd0, 5'(k), imm));
        end
    endtask

    // each instruction reads the register that the one before it wrote
    task automatic aluRegisterOps();
        logic [4:0] lastRd;
        logic [4:0] rd;
        lastRd = randIndex(1, 31);
        for (int rep = 0; rep < regOpCount / 8; rep++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                rd = randIndex(1, 31);
                issue(rWord(opSpecial, lastRd, randIndex(1, 31), rd, 5'd0, regFns[k]));
                lastRd = rd;
            end
        end
    endtask

    task automatic immediateOps();
        logic [15:0] imm;
        for (int rep = 0; rep < immOpCount / 7; rep++)
        begin
            for (int k = 0; k < 7; k++)
            begin
                imm = randImm();
                imm[15] = rep[0];
                issue(iWord(immOps[k], randIndex(1, 31), randIndex(1, 31), imm));
            end
        end
    endtask

    task automatic shiftOps();
        logic [4:0] src;
        logic [4:0] rd;
        logic [4:0] sa;
        // two negative sources that the shifts below leave alone
        issue(iWord(opLui, 5'd0, 5'd30, 16'hf0f0));
        issue(iWord(opAddiu, 5'd0, 5'd29, 16'hff00));
        for (int rep = 0; rep < 4; rep++)
        begin
            src = (rep == 0) ? 5'd30 : ((rep == 1) ? 5'd29 : randIndex(1, 31));
            rd = randIndex(1, 28);
            sa = randIndex(0, 31);
            for (int k = 0; k < 6; k++)
            begin
                if (k < 3)
                    issue(rWord(opSpecial, 5'd0, src, rd, sa, shiftFns[k]));
                else
                    issue(rWord(opSpecial, randIndex(1, 31), src, rd, 5'd0, shiftFns[k]));
            end
        end
    endtask

    task automatic leadingCountOps();
        logic [4:0] src;
        issue(iWord(opAddiu, 5'd0, 5'd28, 16'hffff));
        issue(iWord(opLui, 5'd0, 5'd27, randImm()));
        issue(iWord(opOri, 5'd27, 5'd27, randImm()));
        for (int k = 0; k < 7; k++)
        begin
            src = (k == 0) ? 5'd0 : ((k == 1) ? 5'd28 : ((k == 2) ? 5'd27 : randIndex(1, 31)));
            issue(rWord(opSpecial2, src, 5'd26, 5'd26, 5'd0, fnClo));
            issue(rWord(opSpecial2, src, 5'd26, 5'd26, 5'd0, fnClz));
        end
    endtask

    task automatic zeroRegAndIllegal();
        issue(iWord(opAddiu, 5'd0, 5'd0, 16'h1234));
        issue(rWord(opSpecial, randIndex(1, 31), randIndex(1, 31), 5'd0, 5'd0, fnAdd));
        issue(rWord(opSpecial, 5'd0, 5'd0, 5'd1, 5'd0, fnOr));
        issue(iWord(opLoadWord, randIndex(1, 31), randIndex(1, 31), randImm()));
        issue(rWord(opSpecial, randIndex(1, 31), randIndex(1, 31), randIndex(1, 31), 5'd0, 6'h3f));
        issue(rWord(opSpecial2, randIndex(1, 31), randIndex(1, 31), randIndex(1, 31), 5'd0, 6'h3f));
        // read back every register through a result that is not written
        for (int k = 1; k < `REG_COUNT; k++)
        begin
            issue(rWord(opSpecial, 5'(k), 5'd0, 5'd0, 5'd0, fnAddu));
        end
    endtask

    initial
    begin
        void'($urandom(56));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        for (int k = 0; k < `REG_COUNT; k++)
        begin
            model[k] = '0;
        end
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
        checkEq("resultValid", {31'b0, resultValid}, 32'd0);
        checkEq("illegal", {31'b0, illegal}, 32'd0);
        checkEq("result", result, 32'd0);

        loadRegisters();
        aluRegisterOps();
        immediateOps();
        shiftOps();
        leadingCountOps();
        zeroRegAndIllegal();

        // outputs last one cycle per strobe
        @(negedge clk);
        checkEq("resultValid", {31'b0, resultValid}, 32'd0);
        checkEq("illegal", {31'b0, illegal}, 32'd0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== src/execCore.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module execCore
    import cpuInstrPkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instrValid,
    input  logic [31:0]                  instr,
    output logic [`DATA_WIDTH-1:0]       result,
    output logic [`REG_ADDR_WIDTH-1:0]   resultDest,
    output logic                         resultValid,
    output logic                         illegal
);

    instrId id;
    funcClass func;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
    logic [4:0] shamt;
    logic [`IMM_WIDTH-1:0] imm16;
    logic [`DATA_WIDTH-1:0] dataRs;
    logic [`DATA_WIDTH-1:0] dataRt;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic legal;
    logic wrEn;

    instrClassifier u_classifier (
        .instr   (instr),
        .id      (id),
        .format  (),
        .func    (func),
        .rs      (rs),
        .rt      (rt),
        .destReg (destReg),
        .shamt   (shamt),
        .imm16   (imm16)
    );

    regFile u_regFile (
        .clk    (clk),
        .rst    (rst),
        .rs     (rs),
        .rt     (rt),
        .wrAddr (destReg),
        .wrData (aluOut),
        .wrEn   (wrEn),
        .dataRs (dataRs),
        .dataRt (dataRt)
    );

    alu u_alu (
        .id     (id),
        .func   (func),
        .dataRs (dataRs),
        .dataRt (dataRt),
        .imm16  (imm16),
        .shamt  (shamt),
        .out    (aluOut)
    );

    assign legal = (id != INVALID);
    // writeback happens on the same edge that captures the result
    assign wrEn = instrValid && legal && (destReg != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result <= '0;
            resultDest <= '0;
            resultValid <= 1'b0;
            illegal <= 1'b0;
        end
        else
        begin
            resultValid <= instrValid && legal;
            illegal <= instrValid && !legal;
            if (instrValid)
            begin
                result <= aluOut;
                resultDest <= destReg;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(resultValid && illegal))
        else $error("execCore: result and illegal raised together");

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module regFile
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`REG_ADDR_WIDTH-1:0]   rs,
    input  logic [`REG_ADDR_WIDTH-1:0]   rt,
    input  logic [`REG_ADDR_WIDTH-1:0]   wrAddr,
    input  logic [`DATA_WIDTH-1:0]       wrData,
    input  logic                         wrEn,
    output logic [`DATA_WIDTH-1:0]       dataRs,
    output logic [`DATA_WIDTH-1:0]       dataRt
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int k = 0; k < `REG_COUNT; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (wrEn && wrAddr != '0)
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // reads see the array directly and a write lands at the edge
    assign dataRs = regs[rs];
    assign dataRt = regs[rt];

    assert property (@(posedge clk) disable iff (rst)
        (rs == '0) |-> (dataRs == '0))
        else $error("regFile: register 0 read back %h", dataRs);

    assert property (@(posedge clk) disable iff (rst)
        (rt == '0) |-> (dataRt == '0))
        else $error("regFile: register 0 read back %h", dataRt);

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module alu
    import cpuInstrPkg::*, cpuAluPkg::*;
(
    input  instrId                   id,
    input  funcClass                 func,
    input  logic [`DATA_WIDTH-1:0]   dataRs,
    input  logic [`DATA_WIDTH-1:0]   dataRt,
    input  logic [`IMM_WIDTH-1:0]    imm16,
    input  logic [4:0]               shamt,
    output logic [`DATA_WIDTH-1:0]   out
);

    extMode ext;
    aluOp op;
    logic [`DATA_WIDTH-1:0] extImm;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] srcB;

    // number of leading bits equal to bitVal, scanning down from the MSB
    function automatic logic [`DATA_WIDTH-1:0] countLeading(
        input logic [`DATA_WIDTH-1:0] value,
        input logic bitVal
    );
        logic [`DATA_WIDTH-1:0] count;
        logic stop;
        count = '0;
        stop = 1'b0;
        for (int k = `DATA_WIDTH - 1; k >= 0; k--)
        begin
            if (!stop && value[k] == bitVal)
                count = count + 1'b1;
            else
                stop = 1'b1;
        end
        return count;
    endfunction

    // logical immediates and LUI take the immediate unsigned
    assign ext = (id inside {ANDI, ORI, XORI, LUI}) ? ZERO_EXT : SIGN_EXT;

    always_comb
    begin
        case (id)
            ADD, ADDU, ADDI, ADDIU: op = ALU_ADD;
            SUB, SUBU:              op = ALU_SUB;
            AND, ANDI:              op = ALU_AND;
            OR, ORI:                op = ALU_OR;
            XOR, XORI:              op = ALU_XOR;
            NOR:                    op = ALU_NOR;
            SLT, SLTI:              op = ALU_SLT;
            SLTU, SLTIU:            op = ALU_SLTU;
            SLL, SLLV:              op = ALU_SLL;
            SRL, SRLV:              op = ALU_SRL;
            SRA, SRAV:              op = ALU_SRA;
            LUI:                    op = ALU_LUI;
            CLO:                    op = ALU_CLO;
            CLZ:                    op = ALU_CLZ;
            default:                op = ALU_ZERO;
        endcase
    end

    assign extImm = (ext == SIGN_EXT) ?
        {{(`DATA_WIDTH - `IMM_WIDTH){imm16[`IMM_WIDTH-1]}}, imm16} :
        {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, imm16};

    // operand A carries the shift count for the shift-by-immediate forms
    assign srcA = (id inside {SLL, SRL, SRA}) ? {{(`DATA_WIDTH - 5){1'b0}}, shamt} : dataRs;

    always_comb
    begin
        case (func)
            CALC_I:  srcB = extImm;
            CALC_R:  srcB = dataRt;
            default: srcB = '0;
        endcase
    end

    always_comb
    begin
        case (op)
            ALU_ZERO: out = '0;
            ALU_A:    out = srcA;
            ALU_B:    out = srcB;
            ALU_ADD:  out = srcA + srcB;
            ALU_SUB:  out = srcA - srcB;
            ALU_AND:  out = srcA & srcB;
            ALU_OR:   out = srcA | srcB;
            ALU_XOR:  out = srcA ^ srcB;
            ALU_NOR:  out = ~(srcA | srcB);
            ALU_SLT:  out = {{(`DATA_WIDTH - 1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: out = {{(`DATA_WIDTH - 1){1'b0}}, srcA < srcB};
            ALU_SLL:  out = srcB << srcA[4:0];
            ALU_SRL:  out = srcB >> srcA[4:0];
            ALU_SRA:  out = $unsigned($signed(srcB) >>> srcA[4:0]);
            ALU_LUI:  out = {srcB[`IMM_WIDTH-1:0], {(`DATA_WIDTH - `IMM_WIDTH){1'b0}}};
            ALU_CLO:  out = countLeading(srcA, 1'b1);
            ALU_CLZ:  out = countLeading(srcA, 1'b0);
            default:  out = '0;
        endcase
    end

    // every decoded instruction must reach a real operation
    always_comb
    begin
        assert final (id == INVALID || op != ALU_ZERO)
            else $error("alu: identity %s has no operation", id.name());
    end

endmodule

// ==== src/instrClassifier.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module instrClassifier
    import cpuInstrPkg::*;
(
    input  logic [31:0]                  instr,
    output instrId                       id,
    output instrFormat                   format,
    output funcClass                     func,
    output logic [`REG_ADDR_WIDTH-1:0]   rs,
    output logic [`REG_ADDR_WIDTH-1:0]   rt,
    output logic [`REG_ADDR_WIDTH-1:0]   destReg,
    output logic [4:0]                   shamt,
    output logic [`IMM_WIDTH-1:0]        imm16
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic isRWord;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign shamt = instr[10:6];
    assign imm16 = instr[15:0];

    assign isRWord = (opcode == OP_SPECIAL) || (opcode == OP_SPECIAL2);

    always_comb
    begin
        id = INVALID;
        case (opcode)
            OP_SPECIAL:
            begin
                case (funct)
                    FN_ADD:  id = ADD;
                    FN_ADDU: id = ADDU;
                    FN_SUB:  id = SUB;
                    FN_SUBU: id = SUBU;
                    FN_AND:  id = AND;
                    FN_OR:   id = OR;
                    FN_XOR:  id = XOR;
                    FN_NOR:  id = NOR;
                    FN_SLT:  id = SLT;
                    FN_SLTU: id = SLTU;
                    FN_SLL:  id = SLL;
                    FN_SRL:  id = SRL;
                    FN_SRA:  id = SRA;
                    FN_SLLV: id = SLLV;
                    FN_SRLV: id = SRLV;
                    FN_SRAV: id = SRAV;
                    default: id = INVALID;
                endcase
            end
            OP_SPECIAL2:
            begin
                if (funct == FN_CLO)
                    id = CLO;
                else if (funct == FN_CLZ)
                    id = CLZ;
            end
            OP_ADDI:  id = ADDI;
            OP_ADDIU: id = ADDIU;
            OP_ANDI:  id = ANDI;
            OP_ORI:   id = ORI;
            OP_XORI:  id = XORI;
            OP_SLTI:  id = SLTI;
            OP_SLTIU: id = SLTIU;
            OP_LUI:   id = LUI;
            default:  id = INVALID;
        endcase
    end

    // format follows the opcode group while the function class follows the identity
    assign format = (id == INVALID) ? NONE : (isRWord ? R : I);

    always_comb
    begin
        if (id == INVALID)
            func = OTHER;
        else if (id inside {ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI})
            func = CALC_I;
        else
            func = CALC_R;
    end

    assign destReg = (format == R) ? rd : ((format == I) ? rt : '0);

    always_comb
    begin
        assert final ((format == R && func == CALC_R) || (format == I && func == CALC_I)
                      || (format == NONE && func == OTHER))
            else $error("classifier: format %s and class %s disagree",
                        format.name(), func.name());
    end

endmodule

// ==== src/cpuAluPkg.sv ====
package cpuAluPkg;

    typedef enum logic [4:0] {
        ALU_ZERO,
        ALU_A,
        ALU_B,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_CLO,
        ALU_CLZ
    } aluOp;

    typedef enum logic {
        ZERO_EXT,
        SIGN_EXT
    } extMode;

endpackage

// ==== src/cpuInstrPkg.sv ====
package cpuInstrPkg;

    typedef enum logic [4:0] {
        ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI,
        CLO, CLZ,
        INVALID
    } instrId;

    typedef enum logic [1:0] {R, I, NONE} instrFormat;

    typedef enum logic [1:0] {CALC_R, CALC_I, OTHER} funcClass;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_ADDI     = 6'h08;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_SLTI     = 6'h0a;
    localparam logic [5:0] OP_SLTIU    = 6'h0b;
    localparam logic [5:0] OP_ANDI     = 6'h0c;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_XORI     = 6'h0e;
    localparam logic [5:0] OP_LUI      = 6'h0f;

    // funct codes under special
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // funct codes under special2
    localparam logic [5:0] FN_CLZ = 6'h20;
    localparam logic [5:0] FN_CLO = 6'h21;

endpackage

// ==== src/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// widths fixed by the instruction set
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32
`define IMM_WIDTH 16

`endif
